//--- filelist.f
source/snake_pkg.sv
source/ps2_key_receiver.sv
source/game_controller.sv
source/snake_engine.sv
source/frame_writer.sv
source/snake_top.sv
testbench/snake_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the snake testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module snake_tb \
	-o snake_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/snake_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q -F "** FAIL **" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
if ! grep -q -F "** PASS **" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

//--- testbench/snake_tb.sv
`timescale 1ns/1ns
`default_nettype none

module snake_tb;

	logic clk;
	logic reset;
	logic ps2_clk;
	logic ps2_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [7:0] wb_adr;
	snake_pkg::colour_t wb_dat;
	logic wb_ack;
	snake_pkg::score_t score;
	logic game_over;

	logic [31:0] lfsr;

	// frame buffer side
	int frame_mem [192];
	int write_idx;
	int frame_count;
	int pending;
	int wait_left;
	int hold_adr;
	int hold_dat;

	// game model, phases 0 menu, 1 wait start, 2 playing, 3 over
	// directions 0 none, 1 up, 2 left, 3 down, 4 right
	int bx [16];
	int by [16];
	int len;
	int dir;
	int pend;
	int ax;
	int ay;
	int score_m;
	int phase_m;
	int period_m;
	int cnt;
	int skip;
	int armed;

	snake_top dut0 (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.score(score),
		.game_over(game_over)
	);

	always #5 clk = ~clk;

	// ####################
	// checks and random numbers
	task automatic check_value(input int got, input int expected, input string what);
		if (got != expected) begin
			$display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			$display("** FAIL **");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("** FAIL **");
		$fatal(1, "stopping on timeout");
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// ####################
	// model
	function automatic int is_wall(input int x, input int y);
		return (x == 0 || x == 15 || y == 0 || y == 11) ? 1 : 0;
	endfunction

	function automatic int on_snake(input int x, input int y, input int first);
		int i;
		for (i = first; i < len; i++) begin
			if (bx[i] == x && by[i] == y)
				return 1;
		end
		return 0;
	endfunction

	function automatic int expected_colour(input int x, input int y);
		if (phase_m == 0)
			return int'(snake_pkg::col_black);
		if (phase_m == 3)
			return int'(snake_pkg::col_red);
		if (is_wall(x, y) != 0)
			return int'(snake_pkg::col_blue);
		if (on_snake(x, y, 0) != 0)
			return int'(snake_pkg::col_green);
		if (x == ax && y == ay)
			return int'(snake_pkg::col_red);
		return int'(snake_pkg::col_black);
	endfunction

	function automatic int is_reverse(input int a, input int b);
		return ((a == 1 && b == 3) || (a == 3 && b == 1) || (a == 2 && b == 4)
			|| (a == 4 && b == 2)) ? 1 : 0;
	endfunction

	task automatic model_reset;
		phase_m = 0;
		score_m = 0;
		len = 1;
		dir = 0;
		pend = 0;
		period_m = 4;
		cnt = 0;
		skip = 0;
		armed = 0;
	endtask

	task automatic model_move;
		int i;
		dir = pend;
		for (i = 15; i > 0; i--) begin
			bx[i] = bx[i - 1];
			by[i] = by[i - 1];
		end
		case (dir)
			1: by[0] = by[0] - 1;
			2: bx[0] = bx[0] - 1;
			3: by[0] = by[0] + 1;
			4: bx[0] = bx[0] + 1;
			default: ;
		endcase
		if (is_wall(bx[0], by[0]) != 0 || on_snake(bx[0], by[0], 1) != 0) begin
			phase_m = 3;
		end else if (bx[0] == ax && by[0] == ay) begin
			if (len < 16)
				len = len + 1;
			if (score_m < 255)
				score_m = score_m + 1;
			// walk at least once, then past snake cells
			do begin
				ax = ax + 5;
				if (ax > 14)
					ax = ax - 14;
				ay = ay + 3;
				if (ay > 10)
					ay = ay - 10;
			end while (on_snake(ax, ay, 0) != 0);
		end
	endtask

	task automatic model_frame_end;
		if (phase_m == 2) begin
			if (cnt == period_m - 1) begin
				cnt = 0;
				model_move();
			end else begin
				cnt = cnt + 1;
			end
		end
	endtask

	task automatic model_code(input int code);
		int d;
		if (code == 8'hF0) begin
			armed = 1;
		end else if (armed != 0) begin
			armed = 0;
			if (phase_m == 0 && (code == 8'h16 || code == 8'h1E || code == 8'h26)) begin
				period_m = (code == 8'h16) ? 4 : (code == 8'h1E) ? 2 : 1;
				phase_m = 1;
				bx[0] = 4;
				by[0] = 6;
				ax = 10;
				ay = 6;
				len = 1;
				dir = 0;
				pend = 0;
				score_m = 0;
				// menu black changes to the field within this frame
				skip = 1;
			end
		end else begin
			d = (code == 8'h75) ? 1 : (code == 8'h6B) ? 2 : (code == 8'h72) ? 3
				: (code == 8'h74) ? 4 : 0;
			if (d != 0 && is_reverse(d, dir) == 0)
				pend = d;
			if (d != 0 && phase_m == 1) begin
				phase_m = 2;
				cnt = 0;
			end
		end
	endtask

	task automatic check_frame;
		int i;
		if (skip == 0) begin
			for (i = 0; i < 192; i++)
				check_value(frame_mem[i], expected_colour(i % 16, i / 16), "cell colour");
		end
		skip = 0;
		check_value(int'(score), score_m, "score");
		check_value(int'(game_over), (phase_m == 3) ? 1 : 0, "game_over");
	endtask

	// ####################
	// frame buffer, acks after 0 to 3 cycles
	always @(negedge clk) begin
		if (reset) begin
			wb_ack = 1'b0;
			pending = 0;
			write_idx = 0;
		end else if (wb_ack) begin
			wb_ack = 1'b0;
			check_value(int'(wb_stb), 0, "stb in cycle after ack");
			check_value(int'(wb_cyc), 0, "cyc in cycle after ack");
		end else if (wb_stb) begin
			check_value(int'(wb_cyc), 1, "cyc with stb");
			check_value(int'(wb_we), 1, "we with stb");
			if (pending == 0) begin
				pending = 1;
				hold_adr = int'(wb_adr);
				hold_dat = int'(wb_dat);
				draw_bits(2, wait_left);
				check_value(hold_adr, write_idx, "write address");
			end else begin
				check_value(int'(wb_adr), hold_adr, "held address");
				check_value(int'(wb_dat), hold_dat, "held data");
			end
			if (wait_left == 0) begin
				wb_ack = 1'b1;
				pending = 0;
				frame_mem[write_idx] = hold_dat;
				write_idx = write_idx + 1;
				if (write_idx == 192) begin
					check_frame();
					model_frame_end();
					write_idx = 0;
					frame_count = frame_count + 1;
				end
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

	// ####################
	// stimulus
	task automatic ps2_send(input logic [7:0] code);
		logic [10:0] bits;
		int i;
		bits = {1'b1, ~^code, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(negedge clk);
			ps2_data = bits[i];
			repeat (8) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (8) @(negedge clk);
			ps2_clk = 1'b1;
		end
		repeat (8) @(negedge clk);
	endtask

	task automatic wait_frame_start;
		int f;
		int t;
		f = frame_count;
		t = 0;
		while (!(frame_count != f && write_idx >= 1)) begin
			@(negedge clk);
			t = t + 1;
			if (t > 20000)
				timeout("start of a frame");
		end
	endtask

	task automatic wait_frames(input int n);
		repeat (n) wait_frame_start();
	endtask

	// one byte per frame, right after its first write
	task automatic send_code(input int code);
		wait_frame_start();
		ps2_send(8'(code));
		model_code(code);
	endtask

	task automatic do_reset;
		@(negedge clk);
		reset = 1'b1;
		model_reset();
		repeat (16) @(negedge clk);
		reset = 1'b0;
	endtask

	initial begin
		int k;
		int r;
		clk = 1'b0;
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		wb_ack = 1'b0;
		lfsr = 32'h33bec3eb;
		frame_count = 0;
		write_idx = 0;
		pending = 0;
		wait_left = 0;

		// fast game, straight into the right wall
		do_reset();
		check_value(int'(score), 0, "score after reset");
		check_value(int'(game_over), 0, "game_over after reset");
		wait_frames(2);
		send_code(8'hF0);
		send_code(8'h26);
		send_code(8'h74);
		wait_frames(2);
		// reverse, released down and an unknown code
		send_code(8'h6B);
		send_code(8'hF0);
		send_code(8'h72);
		send_code(8'h1C);
		wait_frames(8);
		check_value(int'(game_over), 1, "game_over at right wall");
		wait_frames(3);

		// medium game with a turn
		do_reset();
		wait_frames(1);
		send_code(8'hF0);
		send_code(8'h1E);
		send_code(8'h75);
		send_code(8'h72);
		wait_frames(3);
		send_code(8'h74);
		wait_frames(30);
		check_value(int'(game_over), 1, "game_over in second game");

		// slow game with random steering
		do_reset();
		wait_frames(1);
		send_code(8'hF0);
		send_code(8'h16);
		send_code(8'h72);
		for (k = 0; k < 80 && phase_m != 3; k++) begin
			draw_bits(3, r);
			case (r)
				0: send_code(8'h75);
				1: send_code(8'h6B);
				2: send_code(8'h72);
				3: send_code(8'h74);
				default: wait_frame_start();
			endcase
		end
		wait_frames(2);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/snake_top.sv
`timescale 1ns/1ns
`default_nettype none

module snake_top (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic ps2_clk,
	input  wire logic ps2_data,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [7:0] wb_adr,
	output snake_pkg::colour_t wb_dat,
	input  wire logic wb_ack,
	output snake_pkg::score_t score,
	output logic game_over
);

	snake_pkg::key_t key;
	logic key_valid;
	logic frame_done;
	logic start_game;
	logic move;
	logic crash;
	logic busy;
	snake_pkg::phase_t phase;
	snake_pkg::cell_x_t scan_x;
	snake_pkg::cell_y_t scan_y;
	snake_pkg::colour_t cell_kind;

	ps2_key_receiver ps2_key_receiver0 (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.key(key),
		.key_valid(key_valid)
	);

	game_controller game_controller0 (
		.clk(clk),
		.reset(reset),
		.key(key),
		.key_valid(key_valid),
		.frame_done(frame_done),
		.crash(crash),
		.phase(phase),
		.start_game(start_game),
		.move(move),
		.game_over(game_over)
	);

	snake_engine snake_engine0 (
		.clk(clk),
		.reset(reset),
		.key(key),
		.key_valid(key_valid),
		.start_game(start_game),
		.move(move),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.cell_kind(cell_kind),
		.busy(busy),
		.crash(crash),
		.score(score)
	);

	// frame buffer master
	frame_writer frame_writer0 (
		.clk(clk),
		.reset(reset),
		.phase(phase),
		.cell_kind(cell_kind),
		.busy(busy),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.frame_done(frame_done),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

//--- source/frame_writer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_writer (
	input  wire logic clk,
	input  wire logic reset,
	input  wire snake_pkg::phase_t phase,
	input  wire snake_pkg::colour_t cell_kind,
	input  wire logic busy,
	output snake_pkg::cell_x_t scan_x,
	output snake_pkg::cell_y_t scan_y,
	output logic frame_done,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [7:0] wb_adr,
	output snake_pkg::colour_t wb_dat,
	input  wire logic wb_ack
);

	typedef enum logic [1:0] {fw_issue, fw_write, fw_gap} fw_state_t;

	fw_state_t state;
	logic [1:0] gap_cnt;
	logic last_cell;
	snake_pkg::colour_t pixel;

	assign last_cell = (scan_x == snake_pkg::cell_x_t'(snake_pkg::grid_w - 1))
		&& (scan_y == snake_pkg::cell_y_t'(snake_pkg::grid_h - 1));

	always_comb begin
		case (phase)
			snake_pkg::ph_menu: pixel = snake_pkg::col_black;
			snake_pkg::ph_over: pixel = snake_pkg::col_red;
			default: pixel = cell_kind;
		endcase
	end

	// ####################
	// write sequencer
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fw_issue;
			gap_cnt <= '0;
			scan_x <= '0;
			scan_y <= '0;
			frame_done <= 1'b0;
			wb_stb <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				fw_issue: begin
					if (!busy) begin
						wb_stb <= 1'b1;
						state <= fw_write;
					end
				end
				fw_write: begin
					if (wb_ack) begin
						wb_stb <= 1'b0;
						if (last_cell) begin
							scan_x <= '0;
							scan_y <= '0;
							frame_done <= 1'b1;
							gap_cnt <= 2'd2;
							state <= fw_gap;
						end else begin
							state <= fw_issue;
							if (scan_x == snake_pkg::cell_x_t'(snake_pkg::grid_w - 1)) begin
								scan_x <= '0;
								scan_y <= scan_y + 4'd1;
							end else begin
								scan_x <= scan_x + 4'd1;
							end
						end
					end
				end
				fw_gap: begin
					// frame_done cycle, then two idle cycles
					if (gap_cnt == 2'd0)
						state <= fw_issue;
					else
						gap_cnt <= gap_cnt - 2'd1;
				end
				default: state <= fw_issue;
			endcase
		end
	end

	// colour latched as the write starts
	always_ff @(posedge clk) begin
		if (state == fw_issue && !busy)
			wb_dat <= pixel;
	end

	assign wb_cyc = wb_stb;
	assign wb_we = wb_stb;
	assign wb_adr = {scan_y, scan_x};

endmodule

`default_nettype wire

//--- source/snake_engine.sv
`timescale 1ns/1ns
`default_nettype none

module snake_engine (
	input  wire logic clk,
	input  wire logic reset,
	input  wire snake_pkg::key_t key,
	input  wire logic key_valid,
	input  wire logic start_game,
	input  wire logic move,
	input  wire snake_pkg::cell_x_t scan_x,
	input  wire snake_pkg::cell_y_t scan_y,
	output snake_pkg::colour_t cell_kind,
	output logic busy,
	output logic crash,
	output snake_pkg::score_t score
);

	typedef enum logic [1:0] {eng_idle, eng_check, eng_walk} eng_state_t;

	eng_state_t state;
	snake_pkg::cell_x_t body_x [snake_pkg::body_max];
	snake_pkg::cell_y_t body_y [snake_pkg::body_max];
	snake_pkg::length_t length;
	snake_pkg::direction_t dir;
	snake_pkg::direction_t pend;
	snake_pkg::direction_t cur_dir;
	snake_pkg::direction_t key_dir;
	snake_pkg::cell_x_t apple_x;
	snake_pkg::cell_y_t apple_y;
	snake_pkg::cell_x_t step_x;
	snake_pkg::cell_y_t step_y;
	logic [4:0] walk_x;
	logic [4:0] walk_y;
	logic walk_free;
	logic head_crash;

	function automatic logic is_wall(snake_pkg::cell_x_t x, snake_pkg::cell_y_t y);
		return (x == '0) || (x == snake_pkg::cell_x_t'(snake_pkg::grid_w - 1))
			|| (y == '0) || (y == snake_pkg::cell_y_t'(snake_pkg::grid_h - 1));
	endfunction

	// segments first .. length-1
	function automatic logic on_body(snake_pkg::cell_x_t x, snake_pkg::cell_y_t y, int first);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < snake_pkg::body_max; i++) begin
			if (i >= first && i < int'(length) && body_x[i] == x && body_y[i] == y)
				hit = 1'b1;
		end
		return hit;
	endfunction

	function automatic logic is_reverse(snake_pkg::direction_t a, snake_pkg::direction_t b);
		return (a == snake_pkg::dir_up && b == snake_pkg::dir_down)
			|| (a == snake_pkg::dir_down && b == snake_pkg::dir_up)
			|| (a == snake_pkg::dir_left && b == snake_pkg::dir_right)
			|| (a == snake_pkg::dir_right && b == snake_pkg::dir_left);
	endfunction

	always_comb begin
		case (key)
			snake_pkg::key_up: key_dir = snake_pkg::dir_up;
			snake_pkg::key_left: key_dir = snake_pkg::dir_left;
			snake_pkg::key_down: key_dir = snake_pkg::dir_down;
			snake_pkg::key_right: key_dir = snake_pkg::dir_right;
			default: key_dir = snake_pkg::dir_none;
		endcase
		cur_dir = move ? pend : dir;
	end

	// next head cell
	always_comb begin
		step_x = body_x[0];
		step_y = body_y[0];
		case (pend)
			snake_pkg::dir_up: step_y = body_y[0] - 4'd1;
			snake_pkg::dir_down: step_y = body_y[0] + 4'd1;
			snake_pkg::dir_left: step_x = body_x[0] - 4'd1;
			snake_pkg::dir_right: step_x = body_x[0] + 4'd1;
			default: ;
		endcase
	end

	// one step of the apple walk
	always_comb begin
		walk_x = {1'b0, apple_x} + 5'(snake_pkg::apple_step_x);
		if (walk_x > 5'(snake_pkg::grid_w - 2))
			walk_x = walk_x - 5'(snake_pkg::grid_w - 2);
		walk_y = {1'b0, apple_y} + 5'(snake_pkg::apple_step_y);
		if (walk_y > 5'(snake_pkg::grid_h - 2))
			walk_y = walk_y - 5'(snake_pkg::grid_h - 2);
		walk_free = !on_body(walk_x[3:0], walk_y[3:0], 0);
	end

	// old tail sits at index length and is not compared
	always_comb begin
		head_crash = is_wall(body_x[0], body_y[0]) || on_body(body_x[0], body_y[0], 1);
	end

	assign busy = (state != eng_idle);

	// ####################
	// control
	always_ff @(posedge clk) begin
		if (reset || start_game) begin
			state <= eng_idle;
			length <= 5'd1;
			dir <= snake_pkg::dir_none;
			pend <= snake_pkg::dir_none;
			crash <= 1'b0;
			score <= '0;
		end else begin
			if (key_valid && key_dir != snake_pkg::dir_none && !is_reverse(key_dir, cur_dir))
				pend <= key_dir;
			case (state)
				eng_idle: begin
					if (move) begin
						dir <= pend;
						state <= eng_check;
					end
				end
				eng_check: begin
					if (head_crash) begin
						crash <= 1'b1;
						state <= eng_idle;
					end else if (body_x[0] == apple_x && body_y[0] == apple_y) begin
						if (length < snake_pkg::length_t'(snake_pkg::body_max))
							length <= length + 5'd1;
						if (score != 8'hFF)
							score <= score + 8'd1;
						state <= eng_walk;
					end else begin
						state <= eng_idle;
					end
				end
				eng_walk: begin
					if (walk_free)
						state <= eng_idle;
				end
				default: state <= eng_idle;
			endcase
		end
	end

	// body shift and apple position
	always_ff @(posedge clk) begin
		if (start_game) begin
			body_x[0] <= snake_pkg::start_x;
			body_y[0] <= snake_pkg::start_y;
			apple_x <= snake_pkg::apple_x0;
			apple_y <= snake_pkg::apple_y0;
		end else if (state == eng_idle && move) begin
			for (int i = snake_pkg::body_max - 1; i > 0; i--) begin
				body_x[i] <= body_x[i - 1];
				body_y[i] <= body_y[i - 1];
			end
			body_x[0] <= step_x;
			body_y[0] <= step_y;
		end else if (state == eng_walk) begin
			apple_x <= walk_x[3:0];
			apple_y <= walk_y[3:0];
		end
	end

	// ####################
	// cell classifier
	always_comb begin
		if (is_wall(scan_x, scan_y))
			cell_kind = snake_pkg::col_blue;
		// head and body share one colour
		else if (on_body(scan_x, scan_y, 0))
			cell_kind = snake_pkg::col_green;
		else if (scan_x == apple_x && scan_y == apple_y)
			cell_kind = snake_pkg::col_red;
		else
			cell_kind = snake_pkg::col_black;
	end

endmodule

`default_nettype wire

//--- source/game_controller.sv
`timescale 1ns/1ns
`default_nettype none

module game_controller (
	input  wire logic clk,
	input  wire logic reset,
	input  wire snake_pkg::key_t key,
	input  wire logic key_valid,
	input  wire logic frame_done,
	input  wire logic crash,
	output snake_pkg::phase_t phase,
	output logic start_game,
	output logic move,
	output logic game_over
);

	logic [2:0] period;
	logic [2:0] frame_cnt;
	logic [2:0] key_period;
	logic number_key;
	logic direction_key;

	always_comb begin
		number_key = 1'b1;
		case (key)
			snake_pkg::key_1: key_period = snake_pkg::period_1;
			snake_pkg::key_2: key_period = snake_pkg::period_2;
			snake_pkg::key_3: key_period = snake_pkg::period_3;
			default: begin
				key_period = snake_pkg::period_1;
				number_key = 1'b0;
			end
		endcase
	end

	assign direction_key = (key == snake_pkg::key_up) || (key == snake_pkg::key_left)
		|| (key == snake_pkg::key_down) || (key == snake_pkg::key_right);

	// ####################
	// phase fsm
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= snake_pkg::ph_menu;
			start_game <= 1'b0;
			period <= snake_pkg::period_1;
			frame_cnt <= '0;
		end else begin
			start_game <= 1'b0;
			case (phase)
				snake_pkg::ph_menu: begin
					if (key_valid && number_key) begin
						period <= key_period;
						start_game <= 1'b1;
						phase <= snake_pkg::ph_wait_start;
					end
				end
				snake_pkg::ph_wait_start: begin
					frame_cnt <= '0;
					if (key_valid && direction_key)
						phase <= snake_pkg::ph_playing;
				end
				snake_pkg::ph_playing: begin
					if (crash)
						phase <= snake_pkg::ph_over;
					else if (frame_done)
						frame_cnt <= move ? 3'd0 : frame_cnt + 3'd1;
				end
				default: ;
			endcase
		end
	end

	// move on the frame that ends each period
	assign move = (phase == snake_pkg::ph_playing) && frame_done && !crash
		&& (frame_cnt == period - 3'd1);

	assign game_over = (phase == snake_pkg::ph_over);

endmodule

`default_nettype wire

//--- source/ps2_key_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_key_receiver (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic ps2_clk,
	input  wire logic ps2_data,
	output snake_pkg::key_t key,
	output logic key_valid
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_prev;
	logic clk_fall;
	logic [10:0] frame;
	logic [3:0] bit_cnt;
	logic frame_ready;
	logic release_armed;
	logic [7:0] code;
	snake_pkg::key_t code_key;

	// line synchronisers, idle lines are high
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					frame_ready <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// lsb first, new bit enters at the top
	always_ff @(posedge clk) begin
		if (clk_fall)
			frame <= {data_sync[1], frame[10:1]};
	end

	assign code = frame[8:1];

	// directions on make codes, numbers on release codes
	always_comb begin
		code_key = snake_pkg::key_none;
		if (release_armed) begin
			case (code)
				snake_pkg::sc_1: code_key = snake_pkg::key_1;
				snake_pkg::sc_2: code_key = snake_pkg::key_2;
				snake_pkg::sc_3: code_key = snake_pkg::key_3;
				default: code_key = snake_pkg::key_none;
			endcase
		end else begin
			case (code)
				snake_pkg::sc_up: code_key = snake_pkg::key_up;
				snake_pkg::sc_left: code_key = snake_pkg::key_left;
				snake_pkg::sc_down: code_key = snake_pkg::key_down;
				snake_pkg::sc_right: code_key = snake_pkg::key_right;
				default: code_key = snake_pkg::key_none;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			release_armed <= 1'b0;
			key_valid <= 1'b0;
			key <= snake_pkg::key_none;
		end else begin
			key_valid <= 1'b0;
			// start bit low and stop bit high
			if (frame_ready && !frame[0] && frame[10]) begin
				if (code == snake_pkg::sc_release) begin
					release_armed <= 1'b1;
				end else begin
					release_armed <= 1'b0;
					if (code_key != snake_pkg::key_none) begin
						key <= code_key;
						key_valid <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/snake_pkg.sv
`default_nettype none

package snake_pkg;

	// ####################
	// grid and snake sizes
	localparam int grid_w = 16;
	localparam int grid_h = 12;
	localparam int body_max = 16;

	typedef logic [3:0] cell_x_t;
	typedef logic [3:0] cell_y_t;
	typedef logic [4:0] length_t;
	typedef logic [7:0] score_t;

	// {red, green, blue}
	typedef enum logic [2:0] {
		col_black = 3'b000,
		col_blue  = 3'b001,
		col_green = 3'b010,
		col_red   = 3'b100
	} colour_t;

	typedef enum logic [2:0] {dir_none, dir_up, dir_left, dir_down, dir_right} direction_t;

	typedef enum logic [2:0] {
		key_none, key_up, key_left, key_down, key_right, key_1, key_2, key_3
	} key_t;

	typedef enum logic [1:0] {ph_menu, ph_wait_start, ph_playing, ph_over} phase_t;

	// ####################
	// ps/2 set 2 scan codes
	localparam logic [7:0] sc_up = 8'h75;
	localparam logic [7:0] sc_left = 8'h6B;
	localparam logic [7:0] sc_down = 8'h72;
	localparam logic [7:0] sc_right = 8'h74;
	localparam logic [7:0] sc_1 = 8'h16;
	localparam logic [7:0] sc_2 = 8'h1E;
	localparam logic [7:0] sc_3 = 8'h26;
	localparam logic [7:0] sc_release = 8'hF0;

	// ####################
	// game constants, periods in frames per move
	localparam logic [2:0] period_1 = 3'd4;
	localparam logic [2:0] period_2 = 3'd2;
	localparam logic [2:0] period_3 = 3'd1;

	localparam cell_x_t start_x = 4'd4;
	localparam cell_y_t start_y = 4'd6;
	localparam cell_x_t apple_x0 = 4'd10;
	localparam cell_y_t apple_y0 = 4'd6;

	// apple walk, wraps inside the playing field
	localparam int apple_step_x = 5;
	localparam int apple_step_y = 3;

endpackage

`default_nettype wire
